//--- common/dma_addr_pkg.sv
package dma_addr_pkg;

  // Address bits inside one core's memory window
  parameter int CORE_ADDR_WIDTH = 16;

  // Slot buffers are aligned to 2^SLOT_LEAD_ZERO bytes
  parameter int SLOT_LEAD_ZERO = 8;

  // Only the bits between the alignment and the window top are stored
  parameter int SLOT_ADDR_EFF_WIDTH = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;

  // Receive data lands this many bytes into the slot buffer
  parameter logic [7:0] RX_WRITE_OFFSET = 8'h0A;

  parameter int LEN_WIDTH = 16;

  parameter logic [LEN_WIDTH-1:0] DEF_MAX_PKT_LEN = 16'd2048;

endpackage

//--- common/dma_msg_pkg.sv
package dma_msg_pkg;

  parameter int MSG_WIDTH = 64;

  // Packet length, dma_addr_pkg::LEN_WIDTH bits wide
  parameter int MSG_LEN_LSB = 0;

  // Slot number of the buffer holding the packet
  parameter int MSG_SLOT_NO_LSB   = 24;
  parameter int MSG_SLOT_NO_WIDTH = 8;

  // Buffer address inside the core window, dma_addr_pkg::CORE_ADDR_WIDTH bits
  parameter int MSG_SLOT_ADDR_LSB = 32;

endpackage

//--- design/desc_fifo.sv
`timescale 1ns/1ns

module desc_fifo #(
  parameter int DEPTH_LOG2 = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] din,
  output logic                  full,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  empty,
  input  logic                  pop
);

  logic [DATA_WIDTH-1:0] mem [0:(1<<DEPTH_LOG2)-1];
  logic [DEPTH_LOG2:0]   wr_ptr;
  logic [DEPTH_LOG2:0]   rd_ptr;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                 (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  // Head is visible without a read strobe
  assign dout = mem[rd_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- rx_desc/slot_addr_table.sv
`timescale 1ns/1ns

module slot_addr_table #(
  parameter int SLOT_COUNT = 16
) (
  input  logic                                       clk,
  input  logic [$clog2(SLOT_COUNT)-1:0]              wr_no,
  input  logic [dma_addr_pkg::SLOT_ADDR_EFF_WIDTH-1:0] wr_data,
  input  logic                                       wr_valid,
  input  logic [$clog2(SLOT_COUNT)-1:0]              lookup_slot,
  output logic [dma_addr_pkg::SLOT_ADDR_EFF_WIDTH-1:0] lookup_addr
);

  logic [dma_addr_pkg::SLOT_ADDR_EFF_WIDTH-1:0] table_mem [0:SLOT_COUNT-1];

  // One table serves every core since the slot layout is shared
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      table_mem[wr_no] <= wr_data;
    end
    lookup_addr <= table_mem[lookup_slot];
  end

endmodule

//--- rx_desc/rx_desc_issue.sv
`timescale 1ns/1ns

module rx_desc_issue #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 16,
  localparam int CORE_NO_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_NO_WIDTH = $clog2(SLOT_COUNT),
  localparam int DESC_WIDTH    = CORE_NO_WIDTH + SLOT_NO_WIDTH,
  localparam int ADDR_WIDTH    = CORE_NO_WIDTH + dma_addr_pkg::CORE_ADDR_WIDTH,
  localparam int EFF_WIDTH     = dma_addr_pkg::SLOT_ADDR_EFF_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [DESC_WIDTH-1:0]              inject_desc,
  input  logic                               inject_desc_valid,
  output logic                               inject_desc_ready,
  input  logic [DESC_WIDTH-1:0]              recycle_desc,
  input  logic                               recycle_valid,
  input  logic [CORE_COUNT-1:0]              drop_list,
  input  logic                               drop_list_valid,
  input  logic [dma_addr_pkg::LEN_WIDTH-1:0] max_pkt_len,
  input  logic                               max_pkt_len_valid,
  input  logic                               incoming_pkt_ready,
  input  logic                               rx_desc_ready,
  output logic [SLOT_NO_WIDTH-1:0]           lookup_slot,
  input  logic [EFF_WIDTH-1:0]               lookup_addr,
  output logic [ADDR_WIDTH-1:0]              rx_desc_addr,
  output logic [dma_addr_pkg::LEN_WIDTH-1:0] rx_desc_len,
  output logic                               rx_desc_valid,
  output logic                               pool_overflow
);

  localparam int PEND_WIDTH = 10;
  localparam int PAD_WIDTH  = dma_addr_pkg::CORE_ADDR_WIDTH - EFF_WIDTH -
                              dma_addr_pkg::SLOT_LEAD_ZERO;

  logic                               pool_full;
  logic                               pool_empty;
  logic                               pool_pop;
  logic [DESC_WIDTH-1:0]              pool_dout;
  logic                               stage_valid;
  logic [CORE_NO_WIDTH-1:0]           stage_core;
  logic [SLOT_NO_WIDTH-1:0]           stage_slot;
  logic                               drop;
  logic [CORE_COUNT-1:0]              drop_list_r;
  logic [dma_addr_pkg::LEN_WIDTH-1:0] max_len_r;
  logic [PEND_WIDTH-1:0]              pend_cnt;
  logic [ADDR_WIDTH-1:0]              addr_base;

  // Recycled slots win over software injection
  assign inject_desc_ready = !pool_full && !recycle_valid;
  assign pool_overflow     = recycle_valid && pool_full;

  desc_fifo #(
    .DEPTH_LOG2($clog2(CORE_COUNT * SLOT_COUNT)),
    .DATA_WIDTH(DESC_WIDTH)
  ) pool_fifo (
    .clk  (clk),
    .rst  (rst),
    .push (recycle_valid || (inject_desc_valid && inject_desc_ready)),
    .din  (recycle_valid ? recycle_desc : inject_desc),
    .full (pool_full),
    .dout (pool_dout),
    .empty(pool_empty),
    .pop  (pool_pop)
  );

  assign drop          = stage_valid && drop_list_r[stage_core];
  assign rx_desc_valid = stage_valid && !drop && rx_desc_ready &&
                         ((pend_cnt != '0) || incoming_pkt_ready);
  assign pool_pop      = !pool_empty && (!stage_valid || drop || rx_desc_valid);

  // A held stage keeps re-reading its own slot so the table output stays put
  assign lookup_slot = pool_pop ? pool_dout[SLOT_NO_WIDTH-1:0] : stage_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (pool_pop) begin
      stage_valid <= 1'b1;
    end else if (drop || rx_desc_valid) begin
      stage_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pool_pop) begin
      stage_core <= pool_dout[DESC_WIDTH-1 -: CORE_NO_WIDTH];
      stage_slot <= pool_dout[SLOT_NO_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r <= '0;
      max_len_r   <= dma_addr_pkg::DEF_MAX_PKT_LEN;
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_r <= max_pkt_len;
      end
    end
  end

  // Packets announced by the MAC but not yet given a buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_cnt <= '0;
    end else if (incoming_pkt_ready && !rx_desc_valid && (pend_cnt != '1)) begin
      pend_cnt <= pend_cnt + 1'b1;
    end else if (rx_desc_valid && !incoming_pkt_ready && (pend_cnt != '0)) begin
      pend_cnt <= pend_cnt - 1'b1;
    end
  end

  assign addr_base    = {stage_core, {PAD_WIDTH{1'b0}}, lookup_addr,
                         {dma_addr_pkg::SLOT_LEAD_ZERO{1'b0}}};
  assign rx_desc_addr = addr_base + ADDR_WIDTH'(dma_addr_pkg::RX_WRITE_OFFSET);
  assign rx_desc_len  = max_len_r;

  a_no_dropped_core: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> !drop_list_r[rx_desc_addr[ADDR_WIDTH-1 -: CORE_NO_WIDTH]]);

endmodule

//--- tx_desc/tx_desc_issue.sv
`timescale 1ns/1ns

module tx_desc_issue #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 16,
  localparam int CORE_NO_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_NO_WIDTH = $clog2(SLOT_COUNT),
  localparam int DESC_WIDTH    = CORE_NO_WIDTH + SLOT_NO_WIDTH,
  localparam int ADDR_WIDTH    = CORE_NO_WIDTH + dma_addr_pkg::CORE_ADDR_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [dma_msg_pkg::MSG_WIDTH-1:0]  msg_data,
  input  logic [CORE_NO_WIDTH-1:0]           msg_core_no,
  input  logic                               msg_valid,
  output logic                               msg_ready,
  input  logic                               tx_desc_ready,
  input  logic                               pkt_sent_out_valid,
  output logic [ADDR_WIDTH-1:0]              tx_desc_addr,
  output logic [dma_addr_pkg::LEN_WIDTH-1:0] tx_desc_len,
  output logic                               tx_desc_valid,
  output logic [DESC_WIDTH-1:0]              recycle_desc,
  output logic                               recycle_valid,
  output logic                               inflight_overflow
);

  logic [dma_addr_pkg::LEN_WIDTH-1:0]       msg_len;
  logic [dma_msg_pkg::MSG_SLOT_NO_WIDTH-1:0] msg_slot;
  logic [dma_addr_pkg::CORE_ADDR_WIDTH-1:0] msg_slot_addr;
  logic [CORE_NO_WIDTH-1:0]                 core_r;
  logic [SLOT_NO_WIDTH-1:0]                 slot_r;
  logic                                     inflight_full;
  logic                                     inflight_empty;

  assign msg_len       = msg_data[dma_msg_pkg::MSG_LEN_LSB +: dma_addr_pkg::LEN_WIDTH];
  assign msg_slot      = msg_data[dma_msg_pkg::MSG_SLOT_NO_LSB +: dma_msg_pkg::MSG_SLOT_NO_WIDTH];
  assign msg_slot_addr = msg_data[dma_msg_pkg::MSG_SLOT_ADDR_LSB +:
                                  dma_addr_pkg::CORE_ADDR_WIDTH];

  assign msg_ready = tx_desc_ready && !tx_desc_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_desc_valid <= 1'b0;
    end else begin
      // Zero length means the core dropped the packet
      tx_desc_valid <= msg_valid && msg_ready && (msg_len != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (msg_valid && msg_ready) begin
      tx_desc_addr <= {msg_core_no, msg_slot_addr};
      tx_desc_len  <= msg_len;
      core_r       <= msg_core_no;
      slot_r       <= msg_slot[SLOT_NO_WIDTH-1:0];
    end
  end

  // Slots stay out of the pool until the MAC has sent them, in issue order
  desc_fifo #(
    .DEPTH_LOG2($clog2(CORE_COUNT)),
    .DATA_WIDTH(DESC_WIDTH)
  ) inflight_fifo (
    .clk  (clk),
    .rst  (rst),
    .push (tx_desc_valid),
    .din  ({core_r, slot_r}),
    .full (inflight_full),
    .dout (recycle_desc),
    .empty(inflight_empty),
    .pop  (recycle_valid)
  );

  assign recycle_valid     = pkt_sent_out_valid && !inflight_empty;
  assign inflight_overflow = tx_desc_valid && inflight_full;

  a_tx_single_pulse: assert property (@(posedge clk) disable iff (rst)
    tx_desc_valid |=> !tx_desc_valid);

endmodule

//--- design/dma_controller.sv
`timescale 1ns/1ns

module dma_controller #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 16,
  localparam int CORE_NO_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_NO_WIDTH = $clog2(SLOT_COUNT),
  localparam int DESC_WIDTH    = CORE_NO_WIDTH + SLOT_NO_WIDTH,
  localparam int ADDR_WIDTH    = CORE_NO_WIDTH + dma_addr_pkg::CORE_ADDR_WIDTH
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [DESC_WIDTH-1:0]                        inject_desc,
  input  logic                                         inject_desc_valid,
  output logic                                         inject_desc_ready,
  input  logic [SLOT_NO_WIDTH-1:0]                     slot_addr_wr_no,
  input  logic [dma_addr_pkg::SLOT_ADDR_EFF_WIDTH-1:0] slot_addr_wr_data,
  input  logic                                         slot_addr_wr_valid,
  input  logic [CORE_COUNT-1:0]                        drop_list,
  input  logic                                         drop_list_valid,
  input  logic [dma_addr_pkg::LEN_WIDTH-1:0]           max_pkt_len,
  input  logic                                         max_pkt_len_valid,
  input  logic                                         incoming_pkt_ready,
  input  logic                                         rx_desc_ready,
  input  logic                                         tx_desc_ready,
  input  logic [dma_msg_pkg::MSG_WIDTH-1:0]            msg_data,
  input  logic [CORE_NO_WIDTH-1:0]                     msg_core_no,
  input  logic                                         msg_valid,
  output logic                                         msg_ready,
  input  logic                                         pkt_sent_out_valid,
  output logic [ADDR_WIDTH-1:0]                        rx_desc_addr,
  output logic [dma_addr_pkg::LEN_WIDTH-1:0]           rx_desc_len,
  output logic                                         rx_desc_valid,
  output logic [ADDR_WIDTH-1:0]                        tx_desc_addr,
  output logic [dma_addr_pkg::LEN_WIDTH-1:0]           tx_desc_len,
  output logic                                         tx_desc_valid,
  output logic                                         err_pool_overflow,
  output logic                                         err_inflight_overflow
);

  logic [DESC_WIDTH-1:0]                        recycle_desc;
  logic                                         recycle_valid;
  logic [SLOT_NO_WIDTH-1:0]                     lookup_slot;
  logic [dma_addr_pkg::SLOT_ADDR_EFF_WIDTH-1:0] lookup_addr;
  logic                                         pool_overflow;
  logic                                         inflight_overflow;

  rx_desc_issue #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) rx_issue (
    .clk               (clk),
    .rst               (rst),
    .inject_desc       (inject_desc),
    .inject_desc_valid (inject_desc_valid),
    .inject_desc_ready (inject_desc_ready),
    .recycle_desc      (recycle_desc),
    .recycle_valid     (recycle_valid),
    .drop_list         (drop_list),
    .drop_list_valid   (drop_list_valid),
    .max_pkt_len       (max_pkt_len),
    .max_pkt_len_valid (max_pkt_len_valid),
    .incoming_pkt_ready(incoming_pkt_ready),
    .rx_desc_ready     (rx_desc_ready),
    .lookup_slot       (lookup_slot),
    .lookup_addr       (lookup_addr),
    .rx_desc_addr      (rx_desc_addr),
    .rx_desc_len       (rx_desc_len),
    .rx_desc_valid     (rx_desc_valid),
    .pool_overflow     (pool_overflow)
  );

  slot_addr_table #(
    .SLOT_COUNT(SLOT_COUNT)
  ) slot_table (
    .clk        (clk),
    .wr_no      (slot_addr_wr_no),
    .wr_data    (slot_addr_wr_data),
    .wr_valid   (slot_addr_wr_valid),
    .lookup_slot(lookup_slot),
    .lookup_addr(lookup_addr)
  );

  tx_desc_issue #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) tx_issue (
    .clk               (clk),
    .rst               (rst),
    .msg_data          (msg_data),
    .msg_core_no       (msg_core_no),
    .msg_valid         (msg_valid),
    .msg_ready         (msg_ready),
    .tx_desc_ready     (tx_desc_ready),
    .pkt_sent_out_valid(pkt_sent_out_valid),
    .tx_desc_addr      (tx_desc_addr),
    .tx_desc_len       (tx_desc_len),
    .tx_desc_valid     (tx_desc_valid),
    .recycle_desc      (recycle_desc),
    .recycle_valid     (recycle_valid),
    .inflight_overflow (inflight_overflow)
  );

  // Error causes stay latched until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      err_pool_overflow     <= 1'b0;
      err_inflight_overflow <= 1'b0;
    end else begin
      if (pool_overflow) begin
        err_pool_overflow <= 1'b1;
      end
      if (inflight_overflow) begin
        err_inflight_overflow <= 1'b1;
      end
    end
  end

endmodule

//--- verif/dma_checker.sv
`timescale 1ns/1ns

module dma_checker (
  input  logic        clk,
  input  logic [3:0]  cur_test,
  input  logic        test_done,
  input  logic [17:0] rx_desc_addr,
  input  logic [15:0] rx_desc_len,
  input  logic        rx_desc_valid,
  input  logic [17:0] tx_desc_addr,
  input  logic [15:0] tx_desc_len,
  input  logic        tx_desc_valid,
  input  logic        err_pool_overflow,
  input  logic        err_inflight_overflow,
  input  logic        inject_desc_ready,
  input  logic        incoming_pkt_ready,
  input  logic        rx_desc_ready,
  input  logic        msg_valid,
  input  logic        msg_ready,
  output int          error_count,
  output int          tests_passed,
  output int          tests_failed
);

  logic [3:0]  rx_test [$];
  logic [17:0] rx_addr [$];
  logic [15:0] rx_len [$];
  logic [3:0]  tx_test [$];
  logic [17:0] tx_addr [$];
  logic [15:0] tx_len [$];
  logic        exp_pool [0:15];
  logic        exp_infl [0:15];
  logic        exp_rdy [0:15];
  int          test_errs;
  int          pkts_announced;
  int          descs_issued;

  task automatic load_expected();
    int          fd;
    int          n;
    string       line;
    logic [3:0]  k;
    logic [3:0]  t;
    logic [15:0] a;
    logic [15:0] b;
    logic [63:0] c;
    fd = $fopen("verif/dma_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/dma_vectors.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h", k, t, a, b, c);
      if (n == 5 && k == 4'h8) begin
        rx_test.push_back(t);
        rx_len.push_back(a);
        rx_addr.push_back(c[17:0]);
      end else if (n == 5 && k == 4'h9) begin
        tx_test.push_back(t);
        tx_len.push_back(a);
        tx_addr.push_back(c[17:0]);
      end else if (n == 5 && k == 4'hA) begin
        exp_pool[t] = a[0];
        exp_infl[t] = b[0];
        exp_rdy[t]  = c[0];
      end
    end
    $fclose(fd);
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, act);
      test_errs++;
      error_count++;
    end
  endtask

  initial begin
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    test_errs      = 0;
    pkts_announced = 0;
    descs_issued   = 0;
    for (int i = 0; i < 16; i++) begin
      exp_pool[i] = 1'b0;
      exp_infl[i] = 1'b0;
      exp_rdy[i]  = 1'b1;
    end
    load_expected();
  end

  // Driven inputs and DUT outputs are settled at the falling edge
  always @(negedge clk) begin
    if (incoming_pkt_ready) begin
      pkts_announced++;
    end
    if (rx_desc_valid) begin
      descs_issued++;
      // Every receive buffer must answer a packet the MAC has announced
      if (descs_issued > pkts_announced) begin
        $display("test %0d: rx descriptor at %0t issued with no packet announced",
                 cur_test, $time);
        test_errs++;
        error_count++;
      end
      if (!rx_desc_ready) begin
        $display("test %0d: rx descriptor at %0t issued while rx_desc_ready was low",
                 cur_test, $time);
        test_errs++;
        error_count++;
      end
    end
    if (rx_desc_valid) begin
      if (rx_test.size() == 0 || rx_test[0] != cur_test) begin
        $display("test %0d: unexpected rx descriptor at %0t with address %0h",
                 cur_test, $time, rx_desc_addr);
        test_errs++;
        error_count++;
      end else begin
        compare("rx_desc_addr", 64'(rx_addr.pop_front()), 64'(rx_desc_addr));
        compare("rx_desc_len", 64'(rx_len.pop_front()), 64'(rx_desc_len));
        void'(rx_test.pop_front());
      end
    end
    // Messages are spaced apart, so each one finds the tx path free
    if (msg_valid) begin
      compare("msg_ready", 64'(1'b1), 64'(msg_ready));
    end
    if (tx_desc_valid) begin
      compare("msg_ready", 64'(1'b0), 64'(msg_ready));
      if (tx_test.size() == 0 || tx_test[0] != cur_test) begin
        $display("test %0d: unexpected tx descriptor at %0t with address %0h",
                 cur_test, $time, tx_desc_addr);
        test_errs++;
        error_count++;
      end else begin
        compare("tx_desc_addr", 64'(tx_addr.pop_front()), 64'(tx_desc_addr));
        compare("tx_desc_len", 64'(tx_len.pop_front()), 64'(tx_desc_len));
        void'(tx_test.pop_front());
      end
    end
    if (test_done) begin
      while (rx_test.size() > 0 && rx_test[0] == cur_test) begin
        $display("test %0d: expected rx descriptor %0h never arrived", cur_test, rx_addr[0]);
        void'(rx_test.pop_front());
        void'(rx_addr.pop_front());
        void'(rx_len.pop_front());
        test_errs++;
        error_count++;
      end
      while (tx_test.size() > 0 && tx_test[0] == cur_test) begin
        $display("test %0d: expected tx descriptor %0h never arrived", cur_test, tx_addr[0]);
        void'(tx_test.pop_front());
        void'(tx_addr.pop_front());
        void'(tx_len.pop_front());
        test_errs++;
        error_count++;
      end
      compare("err_pool_overflow", 64'(exp_pool[cur_test]), 64'(err_pool_overflow));
      compare("err_inflight_overflow", 64'(exp_infl[cur_test]), 64'(err_inflight_overflow));
      compare("inject_desc_ready", 64'(exp_rdy[cur_test]), 64'(inject_desc_ready));
      if (test_errs == 0) begin
        $display("test %0d: passed", cur_test);
        tests_passed++;
      end else begin
        $display("test %0d: failed with %0d errors", cur_test, test_errs);
        tests_failed++;
      end
      test_errs = 0;
    end
  end

endmodule

//--- verif/tb_dma_controller.sv
`timescale 1ns/1ns

module tb_dma_controller;

  localparam int CORE_COUNT     = 4;
  localparam int SLOT_COUNT     = 4;
  localparam int TIMEOUT_MARGIN = 200;

  logic        clk;
  logic        rst;
  logic [3:0]  inject_desc;
  logic        inject_desc_valid;
  logic        inject_desc_ready;
  logic [1:0]  slot_addr_wr_no;
  logic [6:0]  slot_addr_wr_data;
  logic        slot_addr_wr_valid;
  logic [3:0]  drop_list;
  logic        drop_list_valid;
  logic [15:0] max_pkt_len;
  logic        max_pkt_len_valid;
  logic        incoming_pkt_ready;
  logic        rx_desc_ready;
  logic        tx_desc_ready;
  logic [63:0] msg_data;
  logic [1:0]  msg_core_no;
  logic        msg_valid;
  logic        msg_ready;
  logic        pkt_sent_out_valid;
  logic [17:0] rx_desc_addr;
  logic [15:0] rx_desc_len;
  logic        rx_desc_valid;
  logic [17:0] tx_desc_addr;
  logic [15:0] tx_desc_len;
  logic        tx_desc_valid;
  logic        err_pool_overflow;
  logic        err_inflight_overflow;
  logic [3:0]  cur_test;
  logic        test_done;
  int          error_count;
  int          tests_passed;
  int          tests_failed;

  // One entry per stimulus line of the vector file
  logic [3:0]  st_kind [$];
  logic [3:0]  st_test [$];
  logic [15:0] st_a [$];
  logic [15:0] st_b [$];
  logic [63:0] st_c [$];
  int          total_cycles;
  int          cycle_cnt;
  logic [15:0] lfsr;

  dma_controller #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) dut (
    .clk(clk), .rst(rst),
    .inject_desc(inject_desc), .inject_desc_valid(inject_desc_valid),
    .inject_desc_ready(inject_desc_ready),
    .slot_addr_wr_no(slot_addr_wr_no), .slot_addr_wr_data(slot_addr_wr_data),
    .slot_addr_wr_valid(slot_addr_wr_valid),
    .drop_list(drop_list), .drop_list_valid(drop_list_valid),
    .max_pkt_len(max_pkt_len), .max_pkt_len_valid(max_pkt_len_valid),
    .incoming_pkt_ready(incoming_pkt_ready), .rx_desc_ready(rx_desc_ready),
    .tx_desc_ready(tx_desc_ready),
    .msg_data(msg_data), .msg_core_no(msg_core_no), .msg_valid(msg_valid),
    .msg_ready(msg_ready), .pkt_sent_out_valid(pkt_sent_out_valid),
    .rx_desc_addr(rx_desc_addr), .rx_desc_len(rx_desc_len), .rx_desc_valid(rx_desc_valid),
    .tx_desc_addr(tx_desc_addr), .tx_desc_len(tx_desc_len), .tx_desc_valid(tx_desc_valid),
    .err_pool_overflow(err_pool_overflow), .err_inflight_overflow(err_inflight_overflow)
  );

  dma_checker desc_checker (
    .clk(clk), .cur_test(cur_test), .test_done(test_done),
    .rx_desc_addr(rx_desc_addr), .rx_desc_len(rx_desc_len), .rx_desc_valid(rx_desc_valid),
    .tx_desc_addr(tx_desc_addr), .tx_desc_len(tx_desc_len), .tx_desc_valid(tx_desc_valid),
    .err_pool_overflow(err_pool_overflow), .err_inflight_overflow(err_inflight_overflow),
    .inject_desc_ready(inject_desc_ready),
    .incoming_pkt_ready(incoming_pkt_ready), .rx_desc_ready(rx_desc_ready),
    .msg_valid(msg_valid), .msg_ready(msg_ready),
    .error_count(error_count),
    .tests_passed(tests_passed), .tests_failed(tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Idle lines last a count of cycles and an inject line may repeat
  function automatic int line_cycles(input int i);
    if (st_kind[i] == 4'h0) begin
      return int'(st_a[i]);
    end
    if (st_kind[i] == 4'h2 && st_b[i] > 16'd1) begin
      return int'(st_b[i]);
    end
    return 1;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [3:0]  k;
    logic [3:0]  t;
    logic [15:0] a;
    logic [15:0] b;
    logic [63:0] c;
    fd = $fopen("verif/dma_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/dma_vectors.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h", k, t, a, b, c);
      if (n == 5 && k < 4'h8) begin
        st_kind.push_back(k);
        st_test.push_back(t);
        st_a.push_back(a);
        st_b.push_back(b);
        st_c.push_back(c);
        total_cycles += line_cycles(st_kind.size() - 1);
      end
    end
    $fclose(fd);
  endtask

  task automatic clear_strobes();
    inject_desc        = '0;
    inject_desc_valid  = 1'b0;
    slot_addr_wr_no    = '0;
    slot_addr_wr_data  = '0;
    slot_addr_wr_valid = 1'b0;
    drop_list          = '0;
    drop_list_valid    = 1'b0;
    max_pkt_len        = '0;
    max_pkt_len_valid  = 1'b0;
    incoming_pkt_ready = 1'b0;
    msg_data           = '0;
    msg_core_no        = '0;
    msg_valid          = 1'b0;
    pkt_sent_out_valid = 1'b0;
  endtask

  task automatic drive_line(input int i, input int k);
    clear_strobes();
    if ((st_kind[i] == 4'h0 || st_kind[i] == 4'h5) && st_b[i][0]) begin
      rx_desc_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end else begin
      rx_desc_ready = 1'b1;
    end
    case (st_kind[i])
      4'h1: begin
        slot_addr_wr_no    = st_a[i][1:0];
        slot_addr_wr_data  = st_b[i][6:0];
        slot_addr_wr_valid = 1'b1;
      end
      4'h2: begin
        inject_desc       = st_a[i][3:0] + 4'(k);
        inject_desc_valid = 1'b1;
      end
      4'h3: begin
        drop_list       = st_a[i][3:0];
        drop_list_valid = 1'b1;
      end
      4'h4: begin
        max_pkt_len       = st_a[i];
        max_pkt_len_valid = 1'b1;
      end
      4'h5: incoming_pkt_ready = 1'b1;
      4'h6: begin
        msg_core_no = st_a[i][1:0];
        msg_data    = st_c[i];
        msg_valid   = 1'b1;
      end
      4'h7: pkt_sent_out_valid = 1'b1;
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > total_cycles + 3 + TIMEOUT_MARGIN) begin
      $display("timeout: run did not finish within %0d cycles", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int n;
    rst           = 1'b1;
    rx_desc_ready = 1'b1;
    tx_desc_ready = 1'b1;
    cur_test      = '0;
    test_done     = 1'b0;
    lfsr          = 16'd4;
    total_cycles  = 0;
    cycle_cnt     = 0;
    clear_strobes();
    load_stimulus();
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
    for (int i = 0; i < st_kind.size(); i++) begin
      n = line_cycles(i);
      for (int k = 0; k < n; k++) begin
        @(posedge clk);
        #2;
        drive_line(i, k);
        cur_test  = st_test[i];
        test_done = (k == n - 1) &&
                    (i == st_kind.size() - 1 || st_test[i+1] != st_test[i]);
      end
    end
    @(posedge clk);
    #2;
    clear_strobes();
    test_done     = 1'b0;
    rx_desc_ready = 1'b1;
    @(posedge clk);
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/dma_vectors.txt
# kind test a b c, all hex
# 0 idle a=cycles b0=random rx_ready, 1 slot write a=slot b=data, 2 inject a=desc b=count
# 3 drop list a=mask, 4 max len a=len, 5 incoming pulse b0=random rx_ready
# 6 message a=core c=data, 7 packet sent, 8 expect rx a=len c=addr, 9 expect tx a=len c=addr
# A expect flags a=pool overflow b=inflight overflow c=inject ready
1 1 0 01 0
1 1 1 12 0
1 1 2 23 0
1 1 3 7F 0
2 1 1 0 0
2 1 6 0 0
2 1 B 0 0
5 1 0 0 0
5 1 0 0 0
5 1 0 0 0
0 1 A 0 0
8 1 800 0 120A
8 1 800 0 1230A
8 1 800 0 27F0A
4 2 400 0 0
2 2 C 0 0
5 2 0 0 0
0 2 8 0 0
8 2 400 0 3010A
3 3 2 0 0
2 3 4 0 0
2 3 2 0 0
5 3 0 0 0
0 3 6 0 0
3 3 0 0 0
2 3 7 0 0
5 3 0 0 0
0 3 8 0 0
8 3 400 0 230A
8 3 400 0 17F0A
2 4 0 0 0
2 4 5 0 0
2 4 A 0 0
0 4 8 1 0
5 4 0 1 0
5 4 0 1 0
5 4 0 1 0
0 4 28 1 0
0 4 4 0 0
8 4 400 0 10A
8 4 400 0 1120A
8 4 400 0 2230A
6 5 2 0 0000450001000040
0 5 2 0 0
6 5 1 0 0000120002000000
0 5 2 0 0
7 5 0 0 0
0 5 2 0 0
5 5 0 0 0
0 5 8 0 0
9 5 40 0 24500
8 5 400 0 2120A
2 6 0 11 0
0 6 2 0 0
6 6 0 0 0000010000000010
0 6 2 0 0
7 6 0 0 0
0 6 4 0 0
9 6 10 0 100
A 6 1 0 0

//--- dma_controller.f
common/dma_addr_pkg.sv
common/dma_msg_pkg.sv
design/desc_fifo.sv
rx_desc/slot_addr_table.sv
rx_desc/rx_desc_issue.sv
tx_desc/tx_desc_issue.sv
design/dma_controller.sv
verif/dma_checker.sv
verif/tb_dma_controller.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dma_controller.f \
  --top-module tb_dma_controller -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dma_controller)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
